// File: run.sh
#!/bin/sh
# Build and run the testbench with Verilator, result taken from sim.log

rm -f sim.log

verilator --binary --timing --assert -f tb.f --top-module sccb_rx_bridge_tb \
	-o sccb_rx_bridge_sim \
	&& ./obj_dir/sccb_rx_bridge_sim > sim.log 2>&1 \
	|| echo "STATUS: FAIL" >> sim.log

cat sim.log

grep -q "STATUS: FAIL" sim.log && exit 1 || exit 0

// File: src/sccb_apb_pkg.sv
`default_nettype none

`include "sccb_defines.svh"

package sccb_apb_pkg;

	//////////////////////////////////////////////////
	// APB field types

	typedef logic [`SCCB_APB_ADDR_WIDTH-1:0] apb_addr_t;
	typedef logic [`SCCB_APB_DATA_WIDTH-1:0] apb_data_t;

	// One strobe bit per data byte
	typedef logic [`SCCB_APB_DATA_WIDTH/8-1:0] apb_strb_t;

	//////////////////////////////////////////////////
	// Bus structs

	// Requester side of the bus
	typedef struct packed {
		logic      preset_n;
		logic      psel;
		logic      penable;
		logic      pwrite;
		apb_addr_t paddr;
		apb_data_t pwdata;
		apb_strb_t pstrb;
	} apb_req_t;

	// Completer answer
	typedef struct packed {
		logic      pready;
		logic      pslverr;
		apb_data_t prdata;
	} apb_rsp_t;

	//////////////////////////////////////////////////
	// Bridge records

	// Result of a finished APB access, one-cycle pulse
	typedef struct packed {
		logic      valid;
		// Read that returned data
		logic      has_data;
		logic      success;
		apb_data_t data;
	} apb_comp_t;

	// Completion frame received from the far side
	typedef struct packed {
		logic      valid;
		logic      error;
		apb_data_t data;
	} apb_ack_t;

	// Request fields, decoder to requester
	typedef struct packed {
		// Combinational, start word of a request frame
		logic      start;
		logic      pwrite;
		apb_addr_t paddr;
		apb_data_t pwdata;
		apb_strb_t pstrb;
	} req_fields_t;

endpackage

`default_nettype wire

// File: src/sccb_apb_requester.sv
`default_nettype none

module sccb_apb_requester (
	input  wire logic                        rx_clk,
	input  wire logic                        arst_n,
	input  wire sccb_frame_pkg::ll_rx_t      ll,
	input  wire sccb_apb_pkg::req_fields_t   req,
	output sccb_apb_pkg::apb_req_t           apb,
	input  wire sccb_apb_pkg::apb_rsp_t      rsp,
	output sccb_apb_pkg::apb_comp_t          comp
);

	logic preset_q;
	logic psel_q;
	logic penable_q;

	// Merged select and enable
	logic psel_c;
	logic penable_c;

	// Access phase ended by the completer
	logic access_done;

	//////////////////////////////////////////////////
	// Select and enable phases

	always_comb begin
		// Setup phase opens with the start word
		psel_c    = psel_q || req.start;
		// Access phase opens on commit
		penable_c = penable_q || (psel_c && ll.commit);

		// Bad CRC cancels the request
		if (ll.drop) begin
			psel_c    = 1'b0;
			penable_c = 1'b0;
		end
	end

	assign access_done = penable_c && rsp.pready;

	always_ff @(posedge rx_clk or negedge arst_n) begin
		if (!arst_n) begin
			preset_q  <= 1'b0;
			psel_q    <= 1'b0;
			penable_q <= 1'b0;
		end else begin
			// Bus reset held for one cycle past our own reset
			preset_q  <= 1'b1;
			psel_q    <= psel_c;
			penable_q <= penable_c;

			if (access_done) begin
				psel_q    <= 1'b0;
				penable_q <= 1'b0;
			end

			// Link loss abandons a request still in setup
			// An access already in progress waits for pready
			if (!ll.link_up && !penable_c)
				psel_q <= 1'b0;
		end
	end

	//////////////////////////////////////////////////
	// Bus outputs

	always_comb begin
		apb.preset_n = preset_q;
		apb.psel     = psel_c;
		apb.penable  = penable_c;
		apb.pwrite   = req.pwrite;
		apb.paddr    = req.paddr;
		apb.pwdata   = req.pwdata;
		apb.pstrb    = req.pstrb;
	end

	//////////////////////////////////////////////////
	// Completion record

	// Valid for the pready cycle only
	always_comb begin
		comp.valid    = access_done;
		comp.has_data = !req.pwrite && !rsp.pslverr;
		comp.success  = !rsp.pslverr;
		comp.data     = rsp.prdata;
	end

endmodule

`default_nettype wire

// File: src/sccb_defines.svh
`ifndef SCCB_DEFINES_SVH
`define SCCB_DEFINES_SVH

//////////////////////////////////////////////////
// Frame header codes (8b10b K characters on lane 0)

// K27.7, APB write request
`define SCCB_HDR_APB_WRITE 8'hfb

// K28.0, APB read request
`define SCCB_HDR_APB_READ 8'h1c

// K29.7, completion carrying read data
`define SCCB_HDR_COMP_DATA 8'hfd

// K23.7, completion without data
`define SCCB_HDR_COMP_EMPTY 8'hf7

//////////////////////////////////////////////////
// Widths

// Link word, four bytes per word
`define SCCB_LL_DATA_WIDTH 32

// APB bus
`define SCCB_APB_ADDR_WIDTH 32
`define SCCB_APB_DATA_WIDTH 32

// All byte lanes written
`define SCCB_APB_STRB_FULL 4'b1111

`endif

// File: src/sccb_frame_pkg.sv
`default_nettype none

`include "sccb_defines.svh"

package sccb_frame_pkg;

	//////////////////////////////////////////////////
	// Link-layer word types

	// One received word, byte 0 in data[7:0]
	typedef logic [`SCCB_LL_DATA_WIDTH-1:0] ll_word_t;

	// One frame byte
	typedef logic [7:0] ll_byte_t;

	// Count of valid bytes in a word, 0 to 4
	typedef logic [2:0] ll_nvalid_t;

	// Received stream from the link layer
	typedef struct packed {
		// Link is trained and aligned
		logic       link_up;
		// First word of a frame
		logic       start;
		// Word carries payload
		logic       valid;
		ll_nvalid_t nvalid;
		ll_word_t   data;
		// CRC good, frame accepted
		logic       commit;
		// CRC bad or frame aborted
		logic       drop;
	} ll_rx_t;

	//////////////////////////////////////////////////
	// Frame decoder FSM

	typedef enum logic [2:0] {
		IDLE,
		WRITE_1,
		WRITE_2,
		READ_1,
		COMP_1
	} rx_state_t;

endpackage

`default_nettype wire

// File: src/sccb_rx_bridge.sv
`default_nettype none

module sccb_rx_bridge (
	input  wire logic                      rx_clk,
	input  wire logic                      arst_n,
	input  wire sccb_frame_pkg::ll_rx_t    ll,
	output sccb_apb_pkg::apb_req_t         apb,
	input  wire sccb_apb_pkg::apb_rsp_t    rsp,
	output sccb_apb_pkg::apb_comp_t        comp,
	output sccb_apb_pkg::apb_ack_t         ack
);

	// Decoded request, start pulse plus registered fields
	sccb_apb_pkg::req_fields_t req;

	//////////////////////////////////////////////////
	// Frame parsing

	sccb_rx_frame_decoder u_decoder (
		.rx_clk (rx_clk),
		.arst_n (arst_n),
		.ll     (ll),
		.req    (req),
		.ack    (ack)
	);

	//////////////////////////////////////////////////
	// APB requester port

	sccb_apb_requester u_requester (
		.rx_clk (rx_clk),
		.arst_n (arst_n),
		.ll     (ll),
		.req    (req),
		.apb    (apb),
		.rsp    (rsp),
		.comp   (comp)
	);

endmodule

`default_nettype wire

// File: src/sccb_rx_frame_decoder.sv
`default_nettype none

`include "sccb_defines.svh"

module sccb_rx_frame_decoder (
	input  wire logic                      rx_clk,
	input  wire logic                      arst_n,
	input  wire sccb_frame_pkg::ll_rx_t    ll,
	output sccb_apb_pkg::req_fields_t      req,
	output sccb_apb_pkg::apb_ack_t         ack
);

	// Byte pairs of a word, first arrival in the upper half of the result
	function automatic logic [15:0] upper_pair(input sccb_frame_pkg::ll_word_t w);
		return {w[23:16], w[31:24]};
	endfunction

	function automatic logic [15:0] lower_pair(input sccb_frame_pkg::ll_word_t w);
		return {w[7:0], w[15:8]};
	endfunction

	sccb_frame_pkg::rx_state_t state;
	sccb_frame_pkg::ll_byte_t  hdr;
	logic                      hdr_is_req;
	logic                      frame_start;

	// Request payload
	logic                      pwrite_q;
	sccb_apb_pkg::apb_addr_t   paddr_q;
	sccb_apb_pkg::apb_data_t   pwdata_q;
	sccb_apb_pkg::apb_strb_t   pstrb_q;

	// Acknowledgement tracking
	logic                      ack_pending;
	logic                      ack_error_q;
	sccb_apb_pkg::apb_data_t   ack_data_q;

	//////////////////////////////////////////////////
	// Header classification

	// Frame type sits in lane 0 of the start word
	assign hdr = ll.data[7:0];

	// Only the IDLE state accepts a new frame
	assign frame_start = ll.start && (state == sccb_frame_pkg::IDLE);

	always_comb begin
		hdr_is_req = (hdr == `SCCB_HDR_APB_WRITE) || (hdr == `SCCB_HDR_APB_READ);
	end

	//////////////////////////////////////////////////
	// FSM and pending acknowledgement

	always_ff @(posedge rx_clk or negedge arst_n) begin
		if (!arst_n) begin
			state       <= sccb_frame_pkg::IDLE;
			ack_pending <= 1'b0;
		end else begin
			// Completion frame ends either way
			if (ack_pending && (ll.commit || ll.drop))
				ack_pending <= 1'b0;

			case (state)
				sccb_frame_pkg::IDLE: begin
					if (frame_start) begin
						case (hdr)
							`SCCB_HDR_APB_WRITE: state <= sccb_frame_pkg::WRITE_1;
							`SCCB_HDR_APB_READ:  state <= sccb_frame_pkg::READ_1;
							// Single word, no further state
							`SCCB_HDR_COMP_EMPTY: ack_pending <= 1'b1;
							`SCCB_HDR_COMP_DATA: begin
								ack_pending <= 1'b1;
								state       <= sccb_frame_pkg::COMP_1;
							end
							// Unknown header, frame ignored
							default: begin
							end
						endcase
					end
				end

				// Abort if the second word never shows up
				sccb_frame_pkg::WRITE_1: begin
					if (ll.drop || !ll.valid)
						state <= sccb_frame_pkg::IDLE;
					else
						state <= sccb_frame_pkg::WRITE_2;
				end

				// Last payload words, CRC follows
				sccb_frame_pkg::WRITE_2: state <= sccb_frame_pkg::IDLE;
				sccb_frame_pkg::READ_1:  state <= sccb_frame_pkg::IDLE;
				sccb_frame_pkg::COMP_1:  state <= sccb_frame_pkg::IDLE;

				default: state <= sccb_frame_pkg::IDLE;
			endcase

			// Link loss restarts frame parsing
			if (!ll.link_up)
				state <= sccb_frame_pkg::IDLE;
		end
	end

	//////////////////////////////////////////////////
	// Field assembly, one word per cycle

	// Sequence byte in lane 1 is skipped
	always_ff @(posedge rx_clk) begin
		case (state)
			sccb_frame_pkg::IDLE: begin
				if (frame_start) begin
					case (hdr)
						`SCCB_HDR_APB_WRITE: begin
							paddr_q[31:16] <= upper_pair(ll.data);
							pwrite_q       <= 1'b1;
							pstrb_q        <= `SCCB_APB_STRB_FULL;
						end
						`SCCB_HDR_APB_READ: begin
							paddr_q[31:16] <= upper_pair(ll.data);
							pwrite_q       <= 1'b0;
							pstrb_q        <= '0;
						end
						// Success flag in bit 16, no data
						`SCCB_HDR_COMP_EMPTY: begin
							ack_data_q  <= '0;
							ack_error_q <= !ll.data[16];
						end
						`SCCB_HDR_COMP_DATA: begin
							ack_data_q[31:16] <= upper_pair(ll.data);
							ack_error_q       <= 1'b0;
						end
						default: begin
						end
					endcase
				end
			end

			// Low address half, then high data half
			sccb_frame_pkg::WRITE_1: begin
				paddr_q[15:0]   <= lower_pair(ll.data);
				pwdata_q[31:16] <= upper_pair(ll.data);
			end

			sccb_frame_pkg::WRITE_2: pwdata_q[15:0]   <= lower_pair(ll.data);
			sccb_frame_pkg::READ_1:  paddr_q[15:0]    <= lower_pair(ll.data);
			sccb_frame_pkg::COMP_1:  ack_data_q[15:0] <= lower_pair(ll.data);

			default: begin
			end
		endcase
	end

	//////////////////////////////////////////////////
	// Outputs

	always_comb begin
		req.start  = frame_start && hdr_is_req;
		req.pwrite = pwrite_q;
		req.paddr  = paddr_q;
		req.pwdata = pwdata_q;
		req.pstrb  = pstrb_q;

		// Ack fires in the commit cycle itself
		ack.valid = ack_pending && ll.commit;
		ack.error = ack_error_q;
		ack.data  = ack_data_q;
	end

endmodule

`default_nettype wire

// File: tb.f
+incdir+src
src/sccb_frame_pkg.sv
src/sccb_apb_pkg.sv
src/sccb_rx_frame_decoder.sv
src/sccb_apb_requester.sv
src/sccb_rx_bridge.sv
tb/sccb_rx_bridge_sva.sv
tb/sccb_rx_bridge_tb.sv

// File: tb/sccb_rx_bridge_sva.sv
`default_nettype none

module sccb_rx_bridge_sva (
	input wire logic                      rx_clk,
	input wire logic                      arst_n,
	input wire sccb_frame_pkg::ll_rx_t    ll,
	input wire sccb_apb_pkg::apb_req_t    apb,
	input wire sccb_apb_pkg::apb_rsp_t    rsp,
	input wire sccb_apb_pkg::apb_comp_t   comp
);

	//////////////////////////////////////////////////
	// APB protocol

	// Access phase only inside a selected transfer
	penable_needs_psel: assert property (@(posedge rx_clk) disable iff (!arst_n)
		apb.penable |-> apb.psel)
		else $error("penable high while psel is low");

	// Address held through the access phase
	paddr_stable: assert property (@(posedge rx_clk) disable iff (!arst_n)
		(apb.penable && $past(apb.penable)) |-> $stable(apb.paddr))
		else $error("paddr changed during the access phase");

	//////////////////////////////////////////////////
	// Pulse rules

	// Completion in exactly the cycles the completer answers
	comp_with_pready: assert property (@(posedge rx_clk) disable iff (!arst_n)
		comp.valid == rsp.pready)
		else $error("comp.valid and pready differ");

	// Cancelled request leaves the bus idle
	idle_after_drop: assert property (@(posedge rx_clk) disable iff (!arst_n)
		ll.drop |=> (!apb.psel && !apb.penable))
		else $error("psel or penable high one cycle after drop");

endmodule

bind sccb_apb_requester sccb_rx_bridge_sva u_sva (
	.rx_clk (rx_clk),
	.arst_n (arst_n),
	.ll     (ll),
	.apb    (apb),
	.rsp    (rsp),
	.comp   (comp)
);

`default_nettype wire

// File: tb/sccb_rx_bridge_tb.sv
`default_nettype none

`include "sccb_defines.svh"

module sccb_rx_bridge_tb;

	// Frame kinds for the reference model
	localparam logic [1:0] KIND_WRITE      = 2'd0;
	localparam logic [1:0] KIND_READ       = 2'd1;
	localparam logic [1:0] KIND_COMP_EMPTY = 2'd2;
	localparam logic [1:0] KIND_COMP_DATA  = 2'd3;

	// Total frame count used to size the watchdog
	localparam int NUM_FRAMES = 21;

	// Expected pulse where flag means success for comp and error for ack
	typedef struct packed {
		logic                    is_ack;
		logic                    has_data;
		logic                    flag;
		sccb_apb_pkg::apb_data_t data;
	} expect_t;

	logic                      rx_clk = 1'b0;
	logic                      arst_n = 1'b0;
	sccb_frame_pkg::ll_rx_t    ll;
	sccb_apb_pkg::apb_req_t    apb;
	sccb_apb_pkg::apb_rsp_t    rsp = '0;
	sccb_apb_pkg::apb_comp_t   comp;
	sccb_apb_pkg::apb_ack_t    ack;

	integer                    seed = 11;
	logic [31:0]               rnd;
	logic [7:0]                seq_no = 8'h00;
	expect_t                   exp_q[$];
	expect_t                   got_exp;
	sccb_apb_pkg::apb_data_t   shadow [16];
	sccb_apb_pkg::apb_data_t   mem [16];

	// Fields the memory model checks at the start of an access
	logic                      exp_pwrite;
	sccb_apb_pkg::apb_addr_t   exp_paddr;
	sccb_apb_pkg::apb_data_t   exp_pwdata;
	int                        exp_accesses = 0;
	int                        access_count = 0;

	// Memory model wait state
	logic                      busy = 1'b0;
	logic [1:0]                wait_left = 2'd0;
	logic [1:0]                wait_now;
	logic [31:0]               wait_rnd;

	sccb_rx_bridge UUT (
		.rx_clk (rx_clk),
		.arst_n (arst_n),
		.ll     (ll),
		.apb    (apb),
		.rsp    (rsp),
		.comp   (comp),
		.ack    (ack)
	);

	always #2 rx_clk = ~rx_clk;

	//////////////////////////////////////////////////
	// Helpers

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("STATUS: FAIL");
		$fatal(1);
	endtask

	// Fill word built from every index bit
	function automatic sccb_apb_pkg::apb_data_t fill_word(input logic [3:0] idx);
		return {8'hc3, 4'h0, idx, 8'h5a, ~idx, idx};
	endfunction

	// Expected pulse from the frame rules and the shadow memory
	function automatic expect_t expected_result(input logic [1:0] kind,
		input sccb_apb_pkg::apb_addr_t addr, input sccb_apb_pkg::apb_data_t data);
		expect_t e;
		logic    ok;
		ok = (addr[31:24] != 8'hee);
		e  = '0;
		case (kind)
			KIND_WRITE: e.flag = ok;
			KIND_READ: begin
				e.has_data = ok;
				e.flag     = ok;
				e.data     = ok ? shadow[addr[5:2]] : '0;
			end
			// Bit 16 set means the far side succeeded
			KIND_COMP_EMPTY: begin
				e.is_ack = 1'b1;
				e.flag   = !data[16];
			end
			default: begin
				e.is_ack = 1'b1;
				e.data   = data;
			end
		endcase
		return e;
	endfunction

	task automatic drive_word(input logic up, input logic start, input logic valid,
		input sccb_frame_pkg::ll_word_t data);
		@(posedge rx_clk);
		ll.link_up <= up;
		ll.start   <= start;
		ll.valid   <= valid;
		ll.nvalid  <= valid ? 3'd4 : 3'd0;
		ll.data    <= data;
		ll.commit  <= 1'b0;
		ll.drop    <= 1'b0;
	endtask

	// Idle gap then commit or drop for one cycle
	task automatic end_frame(input logic commit);
		drive_word(1'b1, 1'b0, 1'b0, '0);
		@(posedge rx_clk);
		ll.commit <= commit;
		ll.drop   <= !commit;
		drive_word(1'b1, 1'b0, 1'b0, '0);
		seq_no = seq_no + 8'd1;
	endtask

	// Block until every expected pulse has been seen
	task automatic wait_drained();
		while (exp_q.size() != 0)
			@(posedge rx_clk);
		repeat (2) @(posedge rx_clk);
	endtask

	task automatic send_request(input logic is_write, input sccb_apb_pkg::apb_addr_t addr,
		input sccb_apb_pkg::apb_data_t data, input logic commit);
		logic [7:0] hdr;
		hdr        = is_write ? `SCCB_HDR_APB_WRITE : `SCCB_HDR_APB_READ;
		exp_pwrite = is_write;
		exp_paddr  = addr;
		exp_pwdata = data;
		drive_word(1'b1, 1'b1, 1'b1, {addr[23:16], addr[31:24], seq_no, hdr});
		if (is_write) begin
			drive_word(1'b1, 1'b0, 1'b1, {data[23:16], data[31:24], addr[7:0], addr[15:8]});
			drive_word(1'b1, 1'b0, 1'b1, {16'h0000, data[7:0], data[15:8]});
		end else begin
			drive_word(1'b1, 1'b0, 1'b1, {16'h0000, addr[7:0], addr[15:8]});
		end
		// CRC word that the bridge does not check
		rnd = $random(seed);
		drive_word(1'b1, 1'b0, 1'b1, rnd);
		if (commit) begin
			exp_q.push_back(expected_result(is_write ? KIND_WRITE : KIND_READ, addr, data));
			exp_accesses = exp_accesses + 1;
			if (is_write && addr[31:24] != 8'hee)
				shadow[addr[5:2]] = data;
		end
		end_frame(commit);
		wait_drained();
	endtask

	task automatic send_completion(input logic with_data, input sccb_apb_pkg::apb_data_t data,
		input logic commit);
		if (with_data) begin
			drive_word(1'b1, 1'b1, 1'b1,
				{data[23:16], data[31:24], seq_no, `SCCB_HDR_COMP_DATA});
			drive_word(1'b1, 1'b0, 1'b1, {16'h0000, data[7:0], data[15:8]});
		end else begin
			drive_word(1'b1, 1'b1, 1'b1,
				{8'h00, 7'h00, data[16], seq_no, `SCCB_HDR_COMP_EMPTY});
		end
		rnd = $random(seed);
		drive_word(1'b1, 1'b0, 1'b1, rnd);
		if (commit)
			exp_q.push_back(expected_result(with_data ? KIND_COMP_DATA : KIND_COMP_EMPTY,
				'0, data));
		end_frame(commit);
		wait_drained();
	endtask

	//////////////////////////////////////////////////
	// APB memory model with 0 to 2 wait cycles

	always @(posedge rx_clk) begin
		if (!arst_n) begin
			for (int i = 0; i < 16; i++)
				mem[i] <= fill_word(i[3:0]);
			rsp  <= '0;
			busy <= 1'b0;
		end else if (rsp.pready) begin
			rsp  <= '0;
			busy <= 1'b0;
		end else if (apb.psel && apb.penable) begin
			wait_now = wait_left;
			if (!busy) begin
				access_count = access_count + 1;
				assert (apb.pwrite == exp_pwrite) else report_failure($sformatf(
					"Error: apb.pwrite is %h, expected %h", apb.pwrite, exp_pwrite));
				assert (apb.paddr == exp_paddr) else report_failure($sformatf(
					"Error: apb.paddr is %h, expected %h", apb.paddr, exp_paddr));
				assert (apb.pstrb == (exp_pwrite ? `SCCB_APB_STRB_FULL : 4'h0))
					else report_failure($sformatf("Error: apb.pstrb is %h, expected %h",
					apb.pstrb, exp_pwrite ? `SCCB_APB_STRB_FULL : 4'h0));
				assert (!exp_pwrite || apb.pwdata == exp_pwdata) else report_failure(
					$sformatf("Error: apb.pwdata is %h, expected %h", apb.pwdata, exp_pwdata));
				wait_rnd = $random(seed);
				wait_now = wait_rnd[1] ? 2'd2 : {1'b0, wait_rnd[0]};
			end
			busy <= 1'b1;
			if (wait_now == 2'd0) begin
				rsp.pready <= 1'b1;
				if (apb.paddr[31:24] == 8'hee) begin
					rsp.pslverr <= 1'b1;
				end else if (apb.pwrite) begin
					mem[apb.paddr[5:2]] <= apb.pwdata;
				end else begin
					rsp.prdata <= mem[apb.paddr[5:2]];
				end
			end else begin
				wait_left <= wait_now - 2'd1;
			end
		end
	end

	//////////////////////////////////////////////////
	// Comparison of comp and ack pulses

	always @(negedge rx_clk) begin
		if (arst_n && (comp.valid || ack.valid)) begin
			assert (exp_q.size() != 0)
				else report_failure("A completion or acknowledgement pulse came unexpectedly");
			got_exp = exp_q.pop_front();
			if (comp.valid) begin
				assert (!got_exp.is_ack)
					else report_failure("A completion came where an acknowledgement was due");
				assert (comp.has_data == got_exp.has_data) else report_failure($sformatf(
					"Error: comp.has_data is %h, expected %h", comp.has_data, got_exp.has_data));
				assert (comp.success == got_exp.flag) else report_failure($sformatf(
					"Error: comp.success is %h, expected %h", comp.success, got_exp.flag));
				assert (comp.data == got_exp.data) else report_failure($sformatf(
					"Error: comp.data is %h, expected %h", comp.data, got_exp.data));
			end else begin
				assert (got_exp.is_ack)
					else report_failure("An acknowledgement came where a completion was due");
				assert (ack.error == got_exp.flag) else report_failure($sformatf(
					"Error: ack.error is %h, expected %h", ack.error, got_exp.flag));
				assert (ack.data == got_exp.data) else report_failure($sformatf(
					"Error: ack.data is %h, expected %h", ack.data, got_exp.data));
			end
		end
	end

	// Watchdog
	initial begin
		repeat (NUM_FRAMES * 40) @(posedge rx_clk);
		report_failure("The watchdog expired before all frames were processed");
	end

	//////////////////////////////////////////////////
	// Main sequence

	initial begin
		ll = '0;
		for (int i = 0; i < 16; i++)
			shadow[i] = fill_word(i[3:0]);
		repeat (8) @(posedge rx_clk);
		@(negedge rx_clk);
		assert (!apb.preset_n && !apb.psel && !apb.penable && !comp.valid && !ack.valid)
			else report_failure("The bus was not idle and in reset during reset");
		@(posedge rx_clk);
		arst_n  <= 1'b1;
		ll.link_up <= 1'b1;
		@(negedge rx_clk);
		assert (!apb.preset_n) else report_failure("preset_n rose too early after reset");
		@(negedge rx_clk);
		assert (apb.preset_n) else report_failure("preset_n stayed low after reset");

		// Write and read back, then the error address both ways
		send_request(1'b1, 32'h0000_0010, 32'hdead_beef, 1'b1);
		send_request(1'b0, 32'h0000_0010, '0, 1'b1);
		send_request(1'b1, 32'hee00_0004, 32'h1234_5678, 1'b1);
		send_request(1'b0, 32'hee00_0008, '0, 1'b1);

		// Dropped write leaves memory untouched
		send_request(1'b1, 32'h0000_0014, 32'h5555_aaaa, 1'b0);
		send_request(1'b0, 32'h0000_0014, '0, 1'b1);

		// Completion frames
		send_completion(1'b0, 32'h0001_0000, 1'b1);
		send_completion(1'b0, 32'h0000_0000, 1'b1);
		send_completion(1'b1, 32'hcafe_f00d, 1'b1);
		send_completion(1'b1, 32'h0bad_0bad, 1'b0);

		// Unknown header is ignored
		drive_word(1'b1, 1'b1, 1'b1, {16'h1234, seq_no, 8'h55});
		drive_word(1'b1, 1'b0, 1'b1, 32'h0000_0000);
		end_frame(1'b1);
		wait_drained();

		// Write cut by link loss and a stray commit before a clean read
		drive_word(1'b1, 1'b1, 1'b1, {8'h00, 8'h00, seq_no, `SCCB_HDR_APB_WRITE});
		drive_word(1'b0, 1'b0, 1'b0, 32'h0000_0000);
		drive_word(1'b0, 1'b0, 1'b0, 32'h0000_0000);
		end_frame(1'b1);
		repeat (3) @(posedge rx_clk);
		send_request(1'b0, 32'h0000_0010, '0, 1'b1);

		// Random traffic over the memory
		for (int n = 0; n < 8; n++) begin
			rnd = $random(seed);
			send_request(rnd[4], {26'd0, rnd[3:0], 2'b00}, $random(seed), 1'b1);
		end

		assert (access_count == exp_accesses) else report_failure($sformatf(
			"Error: access_count is %h, expected %h", access_count, exp_accesses));
		$display("STATUS: PASS");
		$finish;
	end

endmodule

`default_nettype wire
